//--- Bender.yml
package:
  name: decode_frontend

sources:
  - fe_pkg.sv
  - fe_queue.sv
  - wb_fetch.sv
  - inst_decoder.sv
  - operand_hazard.sv
  - decode_stage.sv
  - decode_frontend.sv
  - target: test
    files:
      - decode_frontend_chk.sv
      - decode_monitor.sv
      - tb_decode_frontend.sv

//--- decode_frontend.sv
module decode_frontend #(
  parameter logic [31:0] RESET_PC    = 32'h8000_0000,
  parameter int          QUEUE_DEPTH = 4
) (
  input  logic             clock,
  input  logic             reset,
  output fe_pkg::wb_req_t  wb_req,
  input  fe_pkg::wb_rsp_t  wb_rsp,
  input  logic             redirect,
  input  logic [31:0]      redirect_pc,
  output logic             out_valid,
  input  logic             out_ready,
  output fe_pkg::decoded_t out_item
);
  import fe_pkg::*;

  logic                             push_valid;
  fetch_item_t                      push_item;
  logic [$clog2(QUEUE_DEPTH+1)-1:0] fetch_count;
  logic                             fq_valid;
  logic                             fq_ready;
  fetch_item_t                      fq_item;
  logic                             ds_valid;
  logic                             ds_ready;
  decoded_t                         ds_item;

  wb_fetch #(
    .RESET_PC (RESET_PC),
    .DEPTH    (QUEUE_DEPTH)
  ) u_wb_fetch (
    .clock       (clock),
    .reset       (reset),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .fetch_count (fetch_count),
    .push_valid  (push_valid),
    .push_item   (push_item)
  );

  // fetch only pushes into guaranteed room, in_ready is not needed
  fe_queue #(
    .DEPTH  (QUEUE_DEPTH),
    .item_t (fetch_item_t)
  ) fetch_queue (
    .clock     (clock),
    .reset     (reset),
    .flush     (redirect),
    .in_valid  (push_valid),
    .in_ready  (),
    .in_item   (push_item),
    .out_valid (fq_valid),
    .out_ready (fq_ready),
    .out_item  (fq_item),
    .count     (fetch_count)
  );

  decode_stage u_decode_stage (
    .clock     (clock),
    .reset     (reset),
    .flush     (redirect),
    .in_valid  (fq_valid),
    .in_ready  (fq_ready),
    .in_item   (fq_item),
    .out_valid (ds_valid),
    .out_ready (ds_ready),
    .out_item  (ds_item)
  );

  fe_queue #(
    .DEPTH  (QUEUE_DEPTH),
    .item_t (decoded_t)
  ) out_queue (
    .clock     (clock),
    .reset     (reset),
    .flush     (redirect),
    .in_valid  (ds_valid),
    .in_ready  (ds_ready),
    .in_item   (ds_item),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_item  (out_item),
    .count     ()
  );

endmodule

//--- decode_frontend_chk.sv
module decode_frontend_chk (
  input logic             clock,
  input logic             reset,
  input fe_pkg::wb_req_t  wb_req,
  input fe_pkg::wb_rsp_t  wb_rsp,
  input logic             redirect,
  input logic             out_valid,
  input logic             out_ready,
  input fe_pkg::decoded_t out_item
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  stb_needs_cyc: assert property (@(posedge clock) wb_req.stb |-> wb_req.cyc)
    else begin
      $error("stb high while cyc is low");
      fail_count++;
    end

  // an open cycle holds its address until the ack
  adr_held: assert property (@(posedge clock) disable iff (reset)
    (wb_req.cyc && !wb_rsp.ack) |=> (wb_req.cyc && wb_req.stb && $stable(wb_req.adr)))
    else begin
      $error("bus request dropped or address changed before ack");
      fail_count++;
    end

  quiet_after_reset: assert property (@(posedge clock) reset |=> (!out_valid && !wb_req.cyc))
    else begin
      $error("out_valid or cyc high right after reset");
      fail_count++;
    end

  out_held: assert property (@(posedge clock) disable iff (reset)
    (out_valid && !out_ready && !redirect) |=> (out_valid && $stable(out_item)))
    else begin
      $error("output record changed while stalled");
      fail_count++;
    end

endmodule

bind decode_frontend decode_frontend_chk u_chk (.*);

//--- decode_monitor.sv
module decode_monitor #(
  parameter logic [31:0] RESET_PC    = 32'h0000_0400,
  parameter int          TABLE_WORDS = 128
) (
  input  logic             clock,
  input  logic             reset,
  input  logic             redirect,
  input  logic [31:0]      redirect_pc,
  input  logic             out_valid,
  input  logic             out_ready,
  input  fe_pkg::decoded_t out_item,
  input  logic [31:0]      table_words [TABLE_WORDS],
  output int               errors,
  output int               transfers
);
  timeunit 1ns;
  timeprecision 1ps;
  import fe_pkg::*;

  localparam int IB = $clog2(TABLE_WORDS);

  logic [31:0] exp_pc;
  decoded_t    exp;
  // reference slot history, slot 1 is the latest
  logic [4:0]  hist_rd1;
  logic [4:0]  hist_rd2;
  logic        hist_load1;

  initial begin
    errors    = 0;
    transfers = 0;
  end

  function automatic alu_op_t base_alu(input logic [2:0] f3);
    case (f3)
      3'd0:    return add;
      3'd1:    return sll;
      3'd2:    return slt;
      3'd3:    return sltu;
      3'd4:    return xor_op;
      3'd5:    return srl;
      3'd6:    return or_op;
      default: return and_op;
    endcase
  endfunction

  function automatic decoded_t model_decode(input logic [31:0] pc, input logic [31:0] w);
    decoded_t   d;
    logic [2:0] f3;
    logic [6:0] f7;
    f3         = w[14:12];
    f7         = w[31:25];
    d          = '0;
    d.pc       = pc;
    d.op_class = illegal;
    d.alu_op   = add;
    case (w[6:0])
      opc_lui:   d.op_class = lui;
      opc_auipc: d.op_class = auipc;
      opc_jal:   d.op_class = jal;
      opc_jalr:  if (f3 == 3'd0) d.op_class = jalr;
      opc_branch: begin
        if (f3 != 3'd2 && f3 != 3'd3) begin
          d.op_class = branch;
          d.alu_op   = alu_op_t'(beq + (f3[2] ? f3 - 3'd2 : f3));
        end
      end
      opc_load:  if (f3 != 3'd3 && f3 < 3'd6) d.op_class = load;
      opc_store: if (f3 < 3'd3) d.op_class = store;
      opc_op_imm: begin
        if ((f3 != 3'd1 && f3 != 3'd5) || f7 == 7'h00 || (f3 == 3'd5 && f7 == 7'h20)) begin
          d.op_class = alu_imm;
          d.alu_op   = (f3 == 3'd5 && f7 == 7'h20) ? sra : base_alu(f3);
        end
      end
      opc_op: begin
        if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
          d.op_class = alu_reg;
          d.alu_op   = (f7 == 7'h20) ? ((f3 == 3'd0) ? sub : sra) : base_alu(f3);
        end
      end
      opc_misc_mem: if (f3 == 3'd1) d.op_class = fence_i;
      opc_system: begin
        if (f3 inside {3'd1, 3'd2, 3'd3}) begin
          d.op_class = csr;
          d.alu_op   = (f3 == 3'd2) ? csr_set : (f3 == 3'd3) ? csr_clear : add;
        end else if (w inside {32'h0000_0073, 32'h0010_0073, 32'h3020_0073}) begin
          d.op_class = system;
        end
      end
      default: d.op_class = illegal;
    endcase
    case (d.op_class)
      lui, auipc:               d.imm = {w[31:12], 12'h000};
      jal:                      d.imm = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
      branch:                   d.imm = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
      store:                    d.imm = 32'($signed({w[31:25], w[11:7]}));
      jalr, load, alu_imm, csr: d.imm = 32'($signed(w[31:20]));
      default:                  d.imm = '0;
    endcase
    if (d.op_class inside {alu_reg, alu_imm, lui, auipc, jal, jalr, load, csr}) d.rd = w[11:7];
    if (d.op_class inside {jalr, branch, load, store, alu_imm, alu_reg, csr}) d.rs1 = w[19:15];
    if (d.op_class inside {branch, store, alu_reg}) d.rs2 = w[24:20];
    if (d.op_class inside {load, store}) d.mem_size = f3[1:0];
    d.mem_sext = (d.op_class == load) && !f3[2];
    if (d.op_class == csr) d.csr_addr = w[31:20];
    d.ecall  = (w == 32'h0000_0073);
    d.ebreak = (w == 32'h0010_0073);
    d.mret   = (w == 32'h3020_0073);
    return d;
  endfunction

  function automatic fwd_t source_of(input logic [4:0] rs);
    if (rs == 5'd0) return fwd_none;
    if (rs == hist_rd1) return fwd_slot1;
    if (rs == hist_rd2) return fwd_slot2;
    return fwd_none;
  endfunction

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    if (got !== want) begin
      $display("Mismatch %s at pc %h: got %h, expected %h", name, exp_pc, got, want);
      errors++;
    end
  endtask

  always @(posedge clock) begin
    if (reset || redirect) begin
      exp_pc     = reset ? RESET_PC : redirect_pc;
      hist_rd1   = 5'd0;
      hist_rd2   = 5'd0;
      hist_load1 = 1'b0;
    end else if (out_valid && out_ready) begin
      exp = model_decode(exp_pc, table_words[exp_pc[IB+1:2]]);
      // a reader of the previous load first takes a bubble slot
      if (hist_load1 && hist_rd1 != 5'd0 && (exp.rs1 == hist_rd1 || exp.rs2 == hist_rd1)) begin
        hist_rd2   = hist_rd1;
        hist_rd1   = 5'd0;
        hist_load1 = 1'b0;
      end
      exp.fwd1 = source_of(exp.rs1);
      exp.fwd2 = source_of(exp.rs2);
      compare_field("pc", out_item.pc, exp.pc);
      compare_field("op_class", out_item.op_class, exp.op_class);
      compare_field("alu_op", out_item.alu_op, exp.alu_op);
      compare_field("imm", out_item.imm, exp.imm);
      compare_field("rs1", out_item.rs1, exp.rs1);
      compare_field("rs2", out_item.rs2, exp.rs2);
      compare_field("rd", out_item.rd, exp.rd);
      compare_field("mem_size", out_item.mem_size, exp.mem_size);
      compare_field("mem_sext", out_item.mem_sext, exp.mem_sext);
      compare_field("csr_addr", out_item.csr_addr, exp.csr_addr);
      compare_field("fwd1", out_item.fwd1, exp.fwd1);
      compare_field("fwd2", out_item.fwd2, exp.fwd2);
      compare_field("ecall", out_item.ecall, exp.ecall);
      compare_field("ebreak", out_item.ebreak, exp.ebreak);
      compare_field("mret", out_item.mret, exp.mret);
      hist_rd2   = hist_rd1;
      hist_rd1   = exp.rd;
      hist_load1 = (exp.op_class == load);
      exp_pc     = exp_pc + 32'd4;
      transfers++;
    end
  end

endmodule

//--- decode_stage.sv
module decode_stage (
  input  logic                clock,
  input  logic                reset,
  input  logic                flush,
  input  logic                in_valid,
  output logic                in_ready,
  input  fe_pkg::fetch_item_t in_item,
  output logic                out_valid,
  input  logic                out_ready,
  output fe_pkg::decoded_t    out_item
);
  import fe_pkg::*;

  decoded_t dec;
  fwd_t     fwd1;
  fwd_t     fwd2;
  logic     load_use;
  logic     can_move;
  logic     accept;

  inst_decoder u_inst_decoder (
    .item (in_item),
    .dec  (dec)
  );

  // a load-use hit steps the history with a bubble and keeps the word
  operand_hazard u_operand_hazard (
    .clock     (clock),
    .reset     (reset),
    .flush     (flush),
    .advance   (in_valid & can_move),
    .bubble_in (load_use),
    .rd_in     (dec.rd),
    .load_in   (dec.op_class == load),
    .rs1       (dec.rs1),
    .rs2       (dec.rs2),
    .fwd1      (fwd1),
    .fwd2      (fwd2),
    .load_use  (load_use)
  );

  // register is free or drains this cycle
  assign can_move = ~out_valid | out_ready;
  assign in_ready = can_move & ~load_use;
  assign accept   = in_valid & in_ready & ~flush;

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      out_valid <= 1'b0;
    end else if (accept) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      out_item      <= dec;
      out_item.fwd1 <= fwd1;
      out_item.fwd2 <= fwd2;
    end
  end

endmodule

//--- fe_pkg.sv
package fe_pkg;

  // instruction class as seen by the later stages
  typedef enum logic [3:0] {
    alu_reg,
    alu_imm,
    lui,
    auipc,
    jal,
    jalr,
    branch,
    load,
    store,
    csr,
    system,
    fence_i,
    illegal
  } op_class_t;

  typedef enum logic [4:0] {
    add,
    sub,
    sll,
    slt,
    sltu,
    xor_op,
    srl,
    sra,
    or_op,
    and_op,
    beq,
    bne,
    blt,
    bge,
    bltu,
    bgeu,
    csr_set,
    csr_clear
  } alu_op_t;

  // operand source, slot 1 is the previous instruction
  typedef enum logic [1:0] {
    fwd_none,
    fwd_slot1,
    fwd_slot2
  } fwd_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] word;
  } fetch_item_t;

  typedef struct packed {
    logic [31:0] pc;
    op_class_t   op_class;
    alu_op_t     alu_op;
    logic [31:0] imm;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    // 0 byte, 1 half, 2 word, same as funct3[1:0]
    logic [1:0]  mem_size;
    logic        mem_sext;
    logic [11:0] csr_addr;
    fwd_t        fwd1;
    fwd_t        fwd2;
    logic        ecall;
    logic        ebreak;
    logic        mret;
  } decoded_t;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic [31:0] adr;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  // major opcodes
  localparam logic [6:0] opc_lui      = 7'b01_101_11;
  localparam logic [6:0] opc_auipc    = 7'b00_101_11;
  localparam logic [6:0] opc_jal      = 7'b11_011_11;
  localparam logic [6:0] opc_jalr     = 7'b11_001_11;
  localparam logic [6:0] opc_branch   = 7'b11_000_11;
  localparam logic [6:0] opc_load     = 7'b00_000_11;
  localparam logic [6:0] opc_store    = 7'b01_000_11;
  localparam logic [6:0] opc_op_imm   = 7'b00_100_11;
  localparam logic [6:0] opc_op       = 7'b01_100_11;
  localparam logic [6:0] opc_misc_mem = 7'b00_011_11;
  localparam logic [6:0] opc_system   = 7'b11_100_11;

endpackage

//--- fe_queue.sv
module fe_queue #(
  parameter int  DEPTH  = 4,
  parameter type item_t = logic [31:0]
) (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       flush,
  input  logic                       in_valid,
  output logic                       in_ready,
  input  item_t                      in_item,
  output logic                       out_valid,
  input  logic                       out_ready,
  output item_t                      out_item,
  output logic [$clog2(DEPTH+1)-1:0] count
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  item_t         mem [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic          push;
  logic          pop;

  // wrap at DEPTH so any depth works, not only powers of two
  function automatic logic [PW-1:0] bump(input logic [PW-1:0] ptr);
    return (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign in_ready  = (count != DEPTH);
  assign out_valid = (count != 0);
  assign out_item  = mem[rd_ptr];

  // nothing moves in a flush cycle
  assign push = in_valid & in_ready & ~flush;
  assign pop  = out_valid & out_ready & ~flush;

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= bump(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= bump(rd_ptr);
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      mem[wr_ptr] <= in_item;
    end
  end

endmodule

//--- inst_decoder.sv
module inst_decoder (
  input  fe_pkg::fetch_item_t item,
  output fe_pkg::decoded_t    dec
);
  import fe_pkg::*;

  localparam logic [31:0] word_ecall  = 32'h0000_0073;
  localparam logic [31:0] word_ebreak = 32'h0010_0073;
  localparam logic [31:0] word_mret   = 32'h3020_0073;

  logic [31:0] w;
  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;
  op_class_t   cls;
  alu_op_t     alu;
  logic        writes_rd;
  logic        reads_rs1;
  logic        reads_rs2;
  logic        is_mem;

  assign w      = item.word;
  assign opcode = w[6:0];
  assign funct3 = w[14:12];
  assign funct7 = w[31:25];

  assign imm_i = {{20{w[31]}}, w[31:20]};
  assign imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
  assign imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
  assign imm_u = {w[31:12], 12'b0};
  assign imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};

  always_comb begin
    cls = illegal;
    alu = add;
    case (opcode)
      opc_lui:   cls = lui;
      opc_auipc: cls = auipc;
      opc_jal:   cls = jal;
      opc_jalr: begin
        if (funct3 == 3'b000) cls = jalr;
      end
      opc_branch: begin
        cls = branch;
        case (funct3)
          3'b000:  alu = beq;
          3'b001:  alu = bne;
          3'b100:  alu = blt;
          3'b101:  alu = bge;
          3'b110:  alu = bltu;
          3'b111:  alu = bgeu;
          default: cls = illegal;
        endcase
      end
      opc_load: begin
        if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) cls = load;
      end
      opc_store: begin
        if (funct3 inside {3'b000, 3'b001, 3'b010}) cls = store;
      end
      opc_op_imm: begin
        cls = alu_imm;
        case (funct3)
          3'b000: alu = add;
          3'b010: alu = slt;
          3'b011: alu = sltu;
          3'b100: alu = xor_op;
          3'b110: alu = or_op;
          3'b111: alu = and_op;
          // shifts carry funct7 in the upper immediate bits
          3'b001: begin
            if (funct7 == 7'b0000000) alu = sll;
            else cls = illegal;
          end
          default: begin
            if (funct7 == 7'b0000000) alu = srl;
            else if (funct7 == 7'b0100000) alu = sra;
            else cls = illegal;
          end
        endcase
      end
      opc_op: begin
        cls = alu_reg;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: alu = add;
          {7'b0100000, 3'b000}: alu = sub;
          {7'b0000000, 3'b001}: alu = sll;
          {7'b0000000, 3'b010}: alu = slt;
          {7'b0000000, 3'b011}: alu = sltu;
          {7'b0000000, 3'b100}: alu = xor_op;
          {7'b0000000, 3'b101}: alu = srl;
          {7'b0100000, 3'b101}: alu = sra;
          {7'b0000000, 3'b110}: alu = or_op;
          {7'b0000000, 3'b111}: alu = and_op;
          // RV32M and anything else
          default: cls = illegal;
        endcase
      end
      opc_misc_mem: begin
        if (funct3 == 3'b001) cls = fence_i;
      end
      opc_system: begin
        case (funct3)
          3'b001: cls = csr;
          3'b010: begin
            cls = csr;
            alu = csr_set;
          end
          3'b011: begin
            cls = csr;
            alu = csr_clear;
          end
          3'b000: begin
            if (w == word_ecall || w == word_ebreak || w == word_mret) cls = system;
          end
          default: cls = illegal;
        endcase
      end
      default: cls = illegal;
    endcase
  end

  assign writes_rd = cls inside {alu_reg, alu_imm, lui, auipc, jal, jalr, load, csr};
  assign reads_rs1 = cls inside {jalr, branch, load, store, alu_imm, alu_reg, csr};
  assign reads_rs2 = cls inside {branch, store, alu_reg};
  assign is_mem    = (cls == load) || (cls == store);

  always_comb begin
    dec          = '0;
    dec.pc       = item.pc;
    dec.op_class = cls;
    dec.alu_op   = alu;
    case (cls)
      lui, auipc:                 dec.imm = imm_u;
      jal:                        dec.imm = imm_j;
      branch:                     dec.imm = imm_b;
      store:                      dec.imm = imm_s;
      jalr, load, alu_imm, csr:   dec.imm = imm_i;
      default:                    dec.imm = '0;
    endcase
    dec.rs1      = reads_rs1 ? w[19:15] : 5'd0;
    dec.rs2      = reads_rs2 ? w[24:20] : 5'd0;
    dec.rd       = writes_rd ? w[11:7] : 5'd0;
    dec.mem_size = is_mem ? funct3[1:0] : 2'd0;
    // unsigned loads have funct3[2] set
    dec.mem_sext = (cls == load) && !funct3[2];
    dec.csr_addr = (cls == csr) ? w[31:20] : 12'd0;
    dec.fwd1     = fwd_none;
    dec.fwd2     = fwd_none;
    dec.ecall    = (w == word_ecall);
    dec.ebreak   = (w == word_ebreak);
    dec.mret     = (w == word_mret);
  end

endmodule

//--- list.f
fe_pkg.sv
fe_queue.sv
wb_fetch.sv
inst_decoder.sv
operand_hazard.sv
decode_stage.sv
decode_frontend.sv
decode_frontend_chk.sv
decode_monitor.sv
tb_decode_frontend.sv

//--- operand_hazard.sv
module operand_hazard (
  input  logic         clock,
  input  logic         reset,
  input  logic         flush,
  input  logic         advance,
  input  logic         bubble_in,
  input  logic [4:0]   rd_in,
  input  logic         load_in,
  input  logic [4:0]   rs1,
  input  logic [4:0]   rs2,
  output fe_pkg::fwd_t fwd1,
  output fe_pkg::fwd_t fwd2,
  output logic         load_use
);
  import fe_pkg::*;

  // slot 1 is the most recent, slot 2 the one before
  logic [4:0] rd_s1;
  logic [4:0] rd_s2;
  logic       load_s1;

  // the nearest producer wins
  function automatic fwd_t pick(input logic [4:0] rs);
    if (rs != 5'd0 && rs == rd_s1) return fwd_slot1;
    if (rs != 5'd0 && rs == rd_s2) return fwd_slot2;
    return fwd_none;
  endfunction

  assign fwd1 = pick(rs1);
  assign fwd2 = pick(rs2);

  // a load result is not ready for the very next slot
  assign load_use = load_s1 &&
                    ((rs1 != 5'd0 && rs1 == rd_s1) || (rs2 != 5'd0 && rs2 == rd_s1));

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      rd_s1   <= 5'd0;
      rd_s2   <= 5'd0;
      load_s1 <= 1'b0;
    end else if (advance) begin
      rd_s2   <= rd_s1;
      rd_s1   <= bubble_in ? 5'd0 : rd_in;
      load_s1 <= load_in & ~bubble_in;
    end
  end

endmodule

//--- tb_decode_frontend.sv
module tb_decode_frontend;
  timeunit 1ns;
  timeprecision 1ps;
  import fe_pkg::*;

  localparam logic [31:0] RESET_PC     = 32'h0000_0400;
  localparam int          QUEUE_DEPTH  = 4;
  localparam int          TABLE_WORDS  = 128;
  localparam int          IB           = $clog2(TABLE_WORDS);
  localparam int          N_TRANSFERS  = 600;
  localparam int          PERIOD_NS    = 8;
  localparam int          RESET_CYCLES = 10;
  // bus waits plus the longest out_ready stall plus a refill after a redirect
  localparam int          WORST_CYCLES = 48;
  localparam int          MARGIN       = 500;
  localparam longint      WATCHDOG_NS  =
    longint'(N_TRANSFERS * WORST_CYCLES + RESET_CYCLES + MARGIN) * PERIOD_NS;

  logic        clock;
  logic        reset;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  logic        redirect;
  logic [31:0] redirect_pc;
  logic        out_valid;
  logic        out_ready;
  decoded_t    out_item;

  logic [31:0] table_words [TABLE_WORDS];
  integer      seed;
  int          errors;
  int          transfers;
  int          redirects;
  int          total;
  int          wait_left;
  int          low_left;
  logic        bus_busy;

  decode_frontend #(
    .RESET_PC    (RESET_PC),
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_decode_frontend (
    .clock       (clock),
    .reset       (reset),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_item    (out_item)
  );

  decode_monitor #(
    .RESET_PC    (RESET_PC),
    .TABLE_WORDS (TABLE_WORDS)
  ) u_decode_monitor (
    .clock       (clock),
    .reset       (reset),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_item    (out_item),
    .table_words (table_words),
    .errors      (errors),
    .transfers   (transfers)
  );

  initial begin
    clock = 1'b0;
    forever #(PERIOD_NS / 2) clock = ~clock;
  end

  // register numbers kept to 0..3 so dependencies and load-use hits are common
  function automatic logic [31:0] make_word();
    logic [31:0] r;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    int          pick;
    r    = $random(seed);
    pick = $unsigned($random(seed)) % 11;
    rd   = {3'b000, r[8:7]};
    rs1  = {3'b000, r[16:15]};
    rs2  = {3'b000, r[21:20]};
    f3   = r[14:12];
    case (pick)
      0: return {r[30] ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd, opc_op};
      1: begin
        // shifts get a mostly legal upper field
        imm = (f3[1:0] == 2'b01) ? {1'b0, r[30], 5'b00000, r[24:20]} : r[31:20];
        return {imm, rs1, f3, rd, opc_op_imm};
      end
      2, 3: return {r[31:20], rs1, f3, rd, opc_load};
      4: return {r[31:25], rs2, rs1, f3, r[11:7], opc_store};
      5: return {r[31:25], rs2, rs1, f3, r[11:7], opc_branch};
      6: return {r[31:12], rd, r[0] ? opc_lui : opc_auipc};
      7: begin
        if (r[0]) return {r[31:12], rd, opc_jal};
        return {r[31:20], rs1, 3'b000, rd, opc_jalr};
      end
      8: return {r[31:20], rs1, f3, rd, opc_system};
      9: begin
        case (r[1:0])
          2'd0:    return 32'h0000_0073;
          2'd1:    return 32'h0010_0073;
          2'd2:    return 32'h3020_0073;
          default: return 32'h0000_100f;
        endcase
      end
      default: return r;
    endcase
  endfunction

  task automatic fill_table();
    for (int i = 0; i < TABLE_WORDS; i++) begin
      table_words[i] = make_word();
    end
  endtask

  // slave side, 0 to 3 wait cycles per request
  task automatic respond_bus();
    if (!wb_req.cyc) begin
      wb_rsp.ack = 1'b0;
      bus_busy   = 1'b0;
    end else begin
      if (!bus_busy) begin
        bus_busy  = 1'b1;
        wait_left = $unsigned($random(seed)) % 4;
      end
      if (wait_left == 0) begin
        wb_rsp.ack = 1'b1;
        wb_rsp.dat = table_words[wb_req.adr[IB+1:2]];
      end else begin
        wait_left--;
      end
    end
  endtask

  task automatic drive_ready();
    if (low_left > 0) begin
      out_ready = 1'b0;
      low_left--;
    end else if ($unsigned($random(seed)) % 24 == 0) begin
      out_ready = 1'b0;
      low_left  = 4 + $unsigned($random(seed)) % 16;
    end else begin
      out_ready = ($unsigned($random(seed)) % 4) != 0;
    end
  endtask

  task automatic drive_redirect();
    if ($unsigned($random(seed)) % 40 == 0) begin
      redirect    = 1'b1;
      redirect_pc = RESET_PC + 32'(($unsigned($random(seed)) % TABLE_WORDS) * 4);
      redirects++;
    end else begin
      redirect = 1'b0;
    end
  endtask

  initial begin
    seed        = 32'hc189;
    reset       = 1'b1;
    wb_rsp      = '0;
    redirect    = 1'b0;
    redirect_pc = '0;
    out_ready   = 1'b0;
    redirects   = 0;
    wait_left   = 0;
    low_left    = 0;
    bus_busy    = 1'b0;
    fill_table();
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    while (transfers < N_TRANSFERS) begin
      @(negedge clock);
      respond_bus();
      drive_ready();
      drive_redirect();
    end
    repeat (3) @(negedge clock);
    total = errors + u_decode_frontend.u_chk.fail_count;
    $display("transfers %0d, redirects %0d, mismatches %0d, assertion failures %0d",
             transfers, redirects, errors, u_decode_frontend.u_chk.fail_count);
    if (total == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: only %0d of %0d transfers arrived", transfers, N_TRANSFERS);
    $display("Errors found");
    $finish;
  end

endmodule

//--- wb_fetch.sv
module wb_fetch #(
  parameter logic [31:0] RESET_PC = 32'h8000_0000,
  parameter int          DEPTH    = 4
) (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       redirect,
  input  logic [31:0]                redirect_pc,
  output fe_pkg::wb_req_t            wb_req,
  input  fe_pkg::wb_rsp_t            wb_rsp,
  input  logic [$clog2(DEPTH+1)-1:0] fetch_count,
  output logic                       push_valid,
  output fe_pkg::fetch_item_t        push_item
);

  // pc of the next request, equal to adr while a cycle is open
  logic [31:0] pc;
  // set when a redirect lands on an open cycle
  logic        discard;
  logic        ack_seen;
  logic        issue;

  assign ack_seen = wb_req.cyc & wb_rsp.ack;

  // only from idle, so there is always one dead cycle after an ack
  // the queue must hold the word this request puts in flight
  assign issue = ~wb_req.cyc & ~redirect & (fetch_count < DEPTH);

  // stale words never reach the queue
  assign push_valid = ack_seen & ~discard & ~redirect;
  assign push_item  = '{pc: wb_req.adr, word: wb_rsp.dat};

  always_ff @(posedge clock) begin
    if (reset) begin
      wb_req  <= '0;
      pc      <= RESET_PC;
      discard <= 1'b0;
    end else begin
      if (ack_seen) begin
        wb_req.cyc <= 1'b0;
        wb_req.stb <= 1'b0;
      end else if (issue) begin
        wb_req.cyc <= 1'b1;
        wb_req.stb <= 1'b1;
        wb_req.adr <= pc;
      end

      if (redirect) begin
        pc <= redirect_pc;
      end else if (push_valid) begin
        pc <= pc + 32'd4;
      end

      // the open cycle still runs to its ack
      if (ack_seen) begin
        discard <= 1'b0;
      end else if (redirect && wb_req.cyc) begin
        discard <= 1'b1;
      end
    end
  end

endmodule
